/* Makefile */
# Verilator build and run for the music box testbench

SIM = obj_dir/VtbMusicBox

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

# Rebuilt only when a source or the file list changes
$(SIM): project.f $(wildcard rtl/*.sv) $(wildcard verif/*.sv)
	verilator --binary --timing --assert --top-module tbMusicBox -f project.f -o VtbMusicBox

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* project.f */
rtl/musicBoxPkg.sv
rtl/tickGenerator.sv
rtl/keyDebouncer.sv
rtl/toneSynth.sv
rtl/dacSerializer.sv
rtl/musicBox.sv
verif/tbMusicBox.sv

/* rtl/dacSerializer.sv */
// Serial DAC output
// Takes a sample over four-phase req/ack and shifts a 16-bit frame MSB first
// DIN changes on SCLK rising, DAC samples on SCLK falling

`timescale 1ns/1ps

module dacSerializer import musicBoxPkg::*; (
	input  logic clock50Mhz,
	input  logic rst,
	input  logic sampleReq,
	output logic sampleAck,
	input  logic [DacWidth-1:0] dacSample,
	output logic spiSclk,
	output logic spiSyncN,
	output logic spiDin
);

	typedef enum logic [1:0] {
		Idle,
		Shift,
		Finish
	} SerialState;

	SerialState state;
	logic [SclkDivWidth-1:0] sclkDiv; // Clocks into the current half period
	logic [BitCountWidth-1:0] bitCount; // Bit on DIN right now
	logic [FrameBits-1:0] shiftReg; // Frame payload
	logic halfDone;

	assign halfDone = (sclkDiv == SclkDivWidth'(SclkHalf - 1));

	//--------------------------------------------------
	// Acknowledge side, drops once the request is gone
	always_ff @(posedge clock50Mhz) begin
		if (rst) begin
			sampleAck <= 1'b0;
		end else if (state == Idle && sampleReq && !sampleAck) begin
			sampleAck <= 1'b1; // Phase 2, one cycle after req
		end else if (sampleAck && !sampleReq) begin
			sampleAck <= 1'b0; // Phase 4
		end
	end

	// Frame FSM
	always_ff @(posedge clock50Mhz) begin
		if (rst) begin
			state <= Idle;
			sclkDiv <= '0;
			bitCount <= '0;
			spiSclk <= 1'b1;
			spiSyncN <= 1'b1;
			spiDin <= 1'b0;
		end else begin
			case (state)
				Idle: begin
					sclkDiv <= '0;
					bitCount <= '0;
					if (sampleReq && !sampleAck) begin
						spiSyncN <= 1'b0; // Frame starts, SCLK still high
						spiDin <= 1'b0; // Top bit is a zero control bit
						state <= Shift;
					end
				end
				Shift: begin
					sclkDiv <= halfDone ? '0 : sclkDiv + 1'b1;
					if (halfDone) begin
						spiSclk <= ~spiSclk;
						if (!spiSclk) begin // Rising edge
							if (bitCount == BitCountWidth'(FrameBits - 1)) begin
								spiSyncN <= 1'b1; // Last falling edge is behind us
								spiDin <= 1'b0;
								state <= Finish;
							end else begin
								bitCount <= bitCount + 1'b1;
								spiDin <= shiftReg[FrameBits-2]; // Next bit
							end
						end
					end
				end
				Finish: begin
					sclkDiv <= halfDone ? '0 : sclkDiv + 1'b1;
					if (halfDone) begin
						state <= Idle; // Minimum SYNC high time met
					end
				end
				default: state <= Idle;
			endcase
		end
	end

	// Payload shifter, loaded at capture
	always_ff @(posedge clock50Mhz) begin
		if (state == Idle && sampleReq && !sampleAck) begin
			shiftReg <= {{(FrameBits - DacWidth){1'b0}}, dacSample};
		end else if (state == Shift && halfDone && !spiSclk) begin
			shiftReg <= shiftReg << 1;
		end
	end

endmodule

/* rtl/keyDebouncer.sv */
// Debouncer for the music keys and the bee switch
// Two-flop synchronizer, per-input run counters stepped on the debounce tick
// Outputs are active high

`timescale 1ns/1ps

module keyDebouncer import musicBoxPkg::*; (
	input  logic clock50Mhz,
	input  logic rst,
	input  logic debounceTick,
	input  logic [NumInputs-1:0] rawInputs, // Active low, bee on top
	output logic [NumKeys-1:0] pressedKeys,
	output logic beePressed
);

	logic [NumInputs-1:0] syncMeta; // First sync stage
	logic [NumInputs-1:0] syncInputs; // Safe to sample
	logic [NumInputs-1:0] debounced; // Still active low
	logic [DebounceRunWidth-1:0] runCount [NumInputs];

	// Raw pins are asynchronous to the clock
	always_ff @(posedge clock50Mhz) begin
		if (rst) begin
			syncMeta <= '1;
			syncInputs <= '1;
		end else begin
			syncMeta <= rawInputs;
			syncInputs <= syncMeta;
		end
	end

	//--------------------------------------------------
	// Run counters, one per input
	always_ff @(posedge clock50Mhz) begin
		if (rst) begin
			debounced <= '1; // Nothing pressed
			for (int i = 0; i < NumInputs; i++) begin
				runCount[i] <= '0;
			end
		end else if (debounceTick) begin
			for (int i = 0; i < NumInputs; i++) begin
				if (syncInputs[i] == debounced[i]) begin
					runCount[i] <= '0; // Run broken
				end else if (runCount[i] == DebounceRunWidth'(DebounceCount - 1)) begin
					debounced[i] <= syncInputs[i]; // Fourth differing sample
					runCount[i] <= '0;
				end else begin
					runCount[i] <= runCount[i] + 1'b1;
				end
			end
		end
	end

	assign pressedKeys = ~debounced[NumKeys-1:0];
	assign beePressed = ~debounced[NumKeys];

endmodule

/* rtl/musicBox.sv */
// Music box top level
// Sample and debounce ticks, key debouncer, tone synthesizer, DAC serializer

`timescale 1ns/1ps

module musicBox import musicBoxPkg::*; (
	input  logic clock50Mhz,
	input  logic rst,
	input  logic [NumKeys-1:0] musicKeys, // Active low
	input  logic beeSwitch, // Active low
	output logic [NumKeys-1:0] keyLeds,
	output logic spiSclk,
	output logic spiSyncN,
	output logic spiDin
);

	logic sampleTick; // 32 kHz enable
	logic debounceTick; // 1 kHz enable
	logic [NumKeys-1:0] pressedKeys;
	logic beePressed;
	logic sampleReq;
	logic sampleAck;
	logic [DacWidth-1:0] dacSample;

	//--------------------------------------------------
	// Clock enables
	tickGenerator #(.Divide(SampleDivide)) i_sampleTick (
		.clock50Mhz(clock50Mhz),
		.rst(rst),
		.tick(sampleTick)
	);

	tickGenerator #(.Divide(DebounceDivide)) i_debounceTick (
		.clock50Mhz(clock50Mhz),
		.rst(rst),
		.tick(debounceTick)
	);

	// Keys and bee share one debouncer
	keyDebouncer i_keyDebouncer (
		.clock50Mhz(clock50Mhz),
		.rst(rst),
		.debounceTick(debounceTick),
		.rawInputs({beeSwitch, musicKeys}),
		.pressedKeys(pressedKeys),
		.beePressed(beePressed)
	);

	assign keyLeds = pressedKeys; // LED lit while key held

	//--------------------------------------------------
	// Audio path
	toneSynth i_toneSynth (
		.clock50Mhz(clock50Mhz),
		.rst(rst),
		.sampleTick(sampleTick),
		.pressedKeys(pressedKeys),
		.beePressed(beePressed),
		.sampleReq(sampleReq),
		.sampleAck(sampleAck),
		.dacSample(dacSample)
	);

	dacSerializer i_dacSerializer (
		.clock50Mhz(clock50Mhz),
		.rst(rst),
		.sampleReq(sampleReq),
		.sampleAck(sampleAck),
		.dacSample(dacSample),
		.spiSclk(spiSclk),
		.spiSyncN(spiSyncN),
		.spiDin(spiDin)
	);

endmodule

/* rtl/musicBoxPkg.sv */
// Music box shared constants
// Tick divides, debounce rules, tone table, audio and DAC widths, SPI framing

package musicBoxPkg;

	//--------------------------------------------------
	// Inputs
	localparam int NumKeys = 6;
	localparam int NumInputs = NumKeys + 1; // Keys plus bee switch on top

	//--------------------------------------------------
	// Clock-enable divides from 50 MHz
	localparam int SampleDivide = 1563; // ~32 kHz sample tick
	localparam int DebounceDivide = 50000; // 1 kHz debounce tick

	localparam int DebounceCount = 4; // Equal samples before a flip
	localparam int DebounceRunWidth = $clog2(DebounceCount + 1);

	//--------------------------------------------------
	// Tones, half periods counted in sample ticks
	localparam int HalfPeriodWidth = 7;
	localparam logic [HalfPeriodWidth-1:0] KeyHalfPeriods [NumKeys] = '{
		7'd61, 7'd54, 7'd48, 7'd45, 7'd40, 7'd36
	};

	localparam int AudioWidth = 8;
	localparam logic [AudioWidth-1:0] KeyAmplitude = 8'd40; // Per sounding key
	localparam int DacWidth = 12;
	localparam int AudioScale = 16; // 256 * 16 = full 12-bit range

	// DAC serial frame, top bits are control and stay zero
	localparam int FrameBits = 16;
	localparam int SclkHalf = 2; // Clocks per SCLK half period
	localparam int BitCountWidth = $clog2(FrameBits);
	localparam int SclkDivWidth = $clog2(SclkHalf);

endpackage

/* rtl/tickGenerator.sv */
// Clock-enable tick generator
// One-cycle pulse every Divide clocks of the 50 MHz clock

`timescale 1ns/1ps

module tickGenerator #(
	parameter int Divide = 1000
) (
	input  logic clock50Mhz,
	input  logic rst,
	output logic tick
);

	localparam int CountWidth = $clog2(Divide);

	logic [CountWidth-1:0] count; // Free-running divider

	always_ff @(posedge clock50Mhz) begin
		if (rst) begin
			count <= '0;
			tick <= 1'b0;
		end else if (count == CountWidth'(Divide - 1)) begin
			count <= '0; // Wrap
			tick <= 1'b1; // First pulse Divide clocks after reset
		end else begin
			count <= count + 1'b1;
			tick <= 1'b0;
		end
	end

endmodule

/* rtl/toneSynth.sv */
// Tone synthesizer
// Bee-mode toggle, six square-wave tone counters, audio mix
// Offers each scaled sample to the DAC side on a four-phase req/ack

`timescale 1ns/1ps

module toneSynth import musicBoxPkg::*; (
	input  logic clock50Mhz,
	input  logic rst,
	input  logic sampleTick,
	input  logic [NumKeys-1:0] pressedKeys,
	input  logic beePressed,
	output logic sampleReq,
	input  logic sampleAck,
	output logic [DacWidth-1:0] dacSample
);

	logic beePrev; // Edge detect on debounced bee
	logic beeMode; // One octave up when set
	logic [HalfPeriodWidth-1:0] toneCount [NumKeys];
	logic [HalfPeriodWidth-1:0] halfPeriod [NumKeys];
	logic [NumKeys-1:0] level; // Square outputs
	logic [NumKeys-1:0] sounding;
	logic [AudioWidth-1:0] audio;

	//--------------------------------------------------
	// Bee mode toggle
	always_ff @(posedge clock50Mhz) begin
		if (rst) begin
			beePrev <= 1'b0;
			beeMode <= 1'b0;
		end else begin
			beePrev <= beePressed;
			if (beePressed && !beePrev) begin
				beeMode <= ~beeMode; // Each press flips it
			end
		end
	end

	// Halving the half period doubles the pitch
	always_comb begin
		for (int k = 0; k < NumKeys; k++) begin
			halfPeriod[k] = beeMode ? (KeyHalfPeriods[k] >> 1) : KeyHalfPeriods[k];
		end
	end

	//--------------------------------------------------
	// Square-wave counters, free running on the sample tick
	always_ff @(posedge clock50Mhz) begin
		if (rst) begin
			level <= '0;
			for (int k = 0; k < NumKeys; k++) begin
				toneCount[k] <= '0;
			end
		end else if (sampleTick) begin
			for (int k = 0; k < NumKeys; k++) begin
				// >= covers a bee switch in the middle of a half period
				if (toneCount[k] >= halfPeriod[k] - 1'b1) begin
					toneCount[k] <= '0;
					level[k] <= ~level[k];
				end else begin
					toneCount[k] <= toneCount[k] + 1'b1;
				end
			end
		end
	end

	// Mix of keys both pressed and high, levels as of this tick
	assign sounding = pressedKeys & level;

	always_comb begin
		audio = '0;
		for (int k = 0; k < NumKeys; k++) begin
			if (sounding[k]) begin
				audio = audio + KeyAmplitude; // Max 6 * 40 = 240
			end
		end
	end

	//--------------------------------------------------
	// Request side of the handshake
	always_ff @(posedge clock50Mhz) begin
		if (rst) begin
			sampleReq <= 1'b0;
		end else if (sampleReq) begin
			if (sampleAck) begin
				sampleReq <= 1'b0; // Phase 3
			end
		end else if (sampleTick && !sampleAck) begin
			sampleReq <= 1'b1; // Busy ticks are skipped
		end
	end

	// Sample register, held stable while the request is up
	always_ff @(posedge clock50Mhz) begin
		if (sampleTick && !sampleReq && !sampleAck) begin
			dacSample <= DacWidth'(audio) * DacWidth'(AudioScale);
		end
	end

endmodule

/* verif/tbMusicBox.sv */
// Testbench for the music box top level
// Clock and reset, LFSR bounce stimulus, SPI frame capture
// Assertion checks on key LEDs and DAC frames, watchdog

`timescale 1ns/1ps

module tbMusicBox;

	localparam int ClocksPerMs = 50000; // 20 ns clock
	localparam int SamplePeriod = 1563; // Clocks per audio sample
	localparam int KeyCode = 40 * 16; // One sounding key, scaled to the DAC
	localparam int BurstEdges = 12; // At most 12 * 6400 clocks so under 2 ms
	localparam time SettleLimit = 4_000_060; // 4 ms plus sync delay
	localparam time WatchdogLimit = 250_000_000; // Test phases ~130 ms plus margin
	localparam int HalfTable [6] = '{61, 54, 48, 45, 40, 36};

	logic clock50Mhz;
	logic rst;
	logic [5:0] musicKeys; // Active low
	logic beeSwitch; // Active low
	logic [5:0] keyLeds;
	logic spiSclk;
	logic spiSyncN;
	logic spiDin;

	logic [15:0] lfsr;
	logic [5:0] ledsHold; // LEDs before the current burst
	logic [5:0] ledsGoal; // LEDs the keys settle to
	time lastEdge; // Last real change on a key input
	int frames [$]; // Captured 12-bit samples
	int frameCount;
	int frameBits;
	logic [15:0] frameShift;
	logic prevSclk;
	logic prevSyncN;
	int value;
	int startCount;

	musicBox i_dut (
		.clock50Mhz(clock50Mhz),
		.rst(rst),
		.musicKeys(musicKeys),
		.beeSwitch(beeSwitch),
		.keyLeds(keyLeds),
		.spiSclk(spiSclk),
		.spiSyncN(spiSyncN),
		.spiDin(spiDin)
	);

	always #10 clock50Mhz = ~clock50Mhz;

	//--------------------------------------------------
	// Error exits
	task automatic haltOnError();
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic flagMismatch(input string name, input int expected, input int actual);
		$display("Fail at %0d ns: %s expected %0d, got %0d", $time, name, expected, actual);
		haltOnError();
	endtask

	task automatic reportError(input string message);
		$display("Error at %0d ns: %s", $time, message);
		haltOnError();
	endtask

	// Galois LFSR on taps 16 14 13 and 11
	function automatic logic [15:0] lfsrNext(input logic [15:0] state);
		return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
	endfunction

	task automatic randomBits(input int count, output int result);
		result = 0;
		for (int i = 0; i < count; i++) begin
			lfsr = lfsrNext(lfsr); // One step per bit
			result = (result << 1) | int'(lfsr[0]);
		end
	endtask

	//--------------------------------------------------
	// Stimulus tasks run on the falling edge
	task automatic driveKey(input logic [2:0] key, input logic level);
		if (musicKeys[key] != level) begin
			lastEdge = $time;
		end
		musicKeys[key] = level;
	endtask

	// Bounce burst then settle and wait for the LED
	task automatic bounceKey(input logic [2:0] key, input logic pressed);
		int coin;
		int hold;
		for (int n = 0; n < BurstEdges; n++) begin
			randomBits(1, coin);
			driveKey(key, coin[0]);
			randomBits(6, hold);
			repeat ((hold + 1) * 100) @(negedge clock50Mhz); // 2 to 128 us
		end
		driveKey(key, ~pressed); // Settled level
		ledsGoal[key] = pressed;
		while (keyLeds != ledsGoal && $time - lastEdge <= SettleLimit) begin
			@(negedge clock50Mhz);
		end
		assert (keyLeds == ledsGoal)
			else flagMismatch("keyLeds", int'(ledsGoal), int'(keyLeds));
		ledsHold = ledsGoal;
	endtask

	task automatic pressBee();
		beeSwitch = 1'b0;
		repeat (5 * ClocksPerMs) @(negedge clock50Mhz); // Past the debounce delay
		beeSwitch = 1'b1;
		repeat (5 * ClocksPerMs) @(negedge clock50Mhz);
	endtask

	//--------------------------------------------------
	// Frame checks
	task automatic popFrame(output int frame);
		while (frames.size() == 0) begin
			@(negedge clock50Mhz);
		end
		frame = frames.pop_front();
	endtask

	// Run lengths of equal frames for one held key
	task automatic measureRuns(input int halfLen, input int numRuns);
		int frame;
		int prev;
		int run;
		frames.delete();
		popFrame(frame); // Sample may predate the key change
		popFrame(frame);
		prev = frame;
		while (frame == prev) begin // Partial first run
			assert (frame == 0 || frame == KeyCode) else flagMismatch("tone frame", KeyCode, frame);
			popFrame(frame);
		end
		for (int r = 0; r < numRuns; r++) begin
			prev = frame;
			run = 0;
			while (frame == prev) begin
				assert (frame == 0 || frame == KeyCode) else flagMismatch("tone frame", KeyCode, frame);
				run++;
				popFrame(frame);
			end
			assert (run == halfLen) else flagMismatch("tone run length", halfLen, run);
		end
	endtask

	// Two held keys show all mix levels within two longest half periods
	task automatic scanChord();
		int frame;
		logic [2:0] seen;
		frames.delete();
		seen = '0;
		for (int n = 0; n < 2 * HalfTable[0]; n++) begin
			popFrame(frame);
			assert (frame % KeyCode == 0 && frame <= 2 * KeyCode)
				else flagMismatch("chord frame", 2 * KeyCode, frame);
			if (frame == 0) begin
				seen[0] = 1'b1;
			end else if (frame == KeyCode) begin
				seen[1] = 1'b1;
			end else begin
				seen[2] = 1'b1;
			end
		end
		assert (seen == 3'b111) else reportError("chord did not show all three mix levels");
	endtask

	//--------------------------------------------------
	// Monitors
	always @(posedge clock50Mhz) begin
		if (!rst) begin
			assert (keyLeds == ledsHold || keyLeds == ledsGoal)
				else flagMismatch("keyLeds", int'(ledsGoal), int'(keyLeds));
		end
	end

	// SPI capture with edges found from the previous cycle
	always @(posedge clock50Mhz) begin
		if (rst) begin
			prevSclk = 1'b1;
			prevSyncN = 1'b1;
			frameBits = 0;
		end else begin
			if (prevSyncN && !spiSyncN) begin
				frameBits = 0; // Frame start
			end
			if (!spiSyncN && prevSclk && !spiSclk) begin
				frameShift = {frameShift[14:0], spiDin}; // DAC samples on falling SCLK
				frameBits++;
			end
			if (!prevSyncN && spiSyncN) begin
				assert (frameBits == 16) else flagMismatch("spi frame bits", 16, frameBits);
				assert (frameShift[15:12] == 4'b0000)
					else flagMismatch("spi control bits", 0, int'(frameShift[15:12]));
				frames.push_back(int'(frameShift[11:0]));
				frameCount++;
			end
			prevSclk = spiSclk;
			prevSyncN = spiSyncN;
		end
	end

	initial begin
		#WatchdogLimit;
		reportError("watchdog expired before the tests finished");
	end

	//--------------------------------------------------
	// Test sequence
	initial begin
		clock50Mhz = 1'b0;
		rst = 1'b1;
		musicKeys = '1; // Nothing pressed
		beeSwitch = 1'b1;
		lfsr = 16'd10802;
		ledsHold = '0;
		ledsGoal = '0;
		lastEdge = 0;
		frameCount = 0;
		repeat (5) @(negedge clock50Mhz);
		rst = 1'b0;
		@(negedge clock50Mhz);
		assert (spiSyncN == 1'b1) else flagMismatch("spiSyncN", 1, int'(spiSyncN));
		assert (keyLeds == '0) else flagMismatch("keyLeds", 0, int'(keyLeds));

		for (int n = 0; n < 20; n++) begin // Silent frames
			popFrame(value);
			assert (value == 0) else flagMismatch("idle frame", 0, value);
		end

		bounceKey(0, 1'b1); // Debounce on press and release
		bounceKey(0, 1'b0);
		bounceKey(1, 1'b1);
		bounceKey(1, 1'b0);

		bounceKey(0, 1'b1);
		measureRuns(HalfTable[0], 3);
		bounceKey(0, 1'b0);
		bounceKey(3, 1'b1);
		measureRuns(HalfTable[3], 3);
		bounceKey(3, 1'b0);

		bounceKey(4, 1'b1); // Chord
		bounceKey(5, 1'b1);
		scanChord();
		bounceKey(4, 1'b0);
		bounceKey(5, 1'b0);

		bounceKey(2, 1'b1);
		pressBee(); // Octave up
		measureRuns(HalfTable[2] / 2, 3);
		pressBee(); // Back to normal pitch
		measureRuns(HalfTable[2], 3);
		bounceKey(2, 1'b0);

		// Frame rate counted away from frame edges
		frames.delete();
		popFrame(value);
		repeat (SamplePeriod / 2) @(negedge clock50Mhz);
		startCount = frameCount;
		repeat (100 * SamplePeriod) @(negedge clock50Mhz);
		assert (frameCount - startCount == 100)
			else flagMismatch("frame count", 100, frameCount - startCount);

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule
